// ==== build.f ====
+incdir+design
design/track_pkg.sv
design/uop_pkg.sv
design/dispatch.sv
design/busy_table.sv
design/rob_tracker.sv
design/sq_tracker.sv
design/dispatch_top.sv
test/dispatch_chk.sv
test/dispatch_tb.sv

// ==== design/busy_table.sv ====
`include "dispatch_cfg.svh"

module busy_table (
  input  logic            clock,
  input  logic            arst_n,
  input  logic            flush_valid,
  // read ports
  input  uop_pkg::preg_t  rd_preg1,
  input  uop_pkg::preg_t  rd_preg2,
  output logic            src1_busy,
  output logic            src2_busy,
  // set from dispatch
  input  logic            alloc_en,
  input  uop_pkg::preg_t  alloc_preg,
  // clear from writeback
  input  logic            wb_valid,
  input  uop_pkg::preg_t  wb_preg
);

  logic [`PREG_NUM-1:0] busy_q;
  logic [`PREG_NUM-1:0] busy_d;

  always_comb begin
    busy_d = busy_q;
    if (wb_valid)
      busy_d[wb_preg] = 1'b0;
    if (alloc_en)
      busy_d[alloc_preg] = 1'b1;  // set wins over same cycle clear
    busy_d[0] = 1'b0;  // x0 mapping is always ready
    if (flush_valid)
      busy_d = '0;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // a writeback in this cycle already counts as ready
  assign src1_busy = busy_q[rd_preg1] & ~(wb_valid & (wb_preg == rd_preg1));
  assign src2_busy = busy_q[rd_preg2] & ~(wb_valid & (wb_preg == rd_preg2));

endmodule

// ==== design/dispatch.sv ====
module dispatch (
  // from rename
  input  logic                   in_valid,
  output logic                   in_ready,
  input  uop_pkg::renamed_uop_t  in_uop,
  // issue queue
  input  logic                   iq_can_alloc,
  output logic                   iq_enq_valid,
  output uop_pkg::iq_entry_t     iq_entry,
  // rob
  input  logic                   rob_can_enq,
  input  track_pkg::rob_id_t     rob_id,
  input  track_pkg::rob_state_e  rob_state,
  output logic                   rob_enq,
  output track_pkg::rob_entry_t  rob_entry,
  // store queue
  input  logic                   sq_can_alloc,
  input  track_pkg::sq_id_t      sq_id,
  output logic                   sq_enq,
  output track_pkg::rob_id_t     sq_robid,
  output uop_pkg::pc_t           sq_pc,
  // busy table
  output uop_pkg::preg_t         rd_preg1,
  output uop_pkg::preg_t         rd_preg2,
  input  logic                   src1_busy,
  input  logic                   src2_busy,
  output logic                   alloc_en,
  output uop_pkg::preg_t         alloc_preg,
  input  logic                   flush_valid
);

  logic sq_ok;
  logic fire;

  // only stores need a store queue slot
  assign sq_ok = ~in_uop.is_store | sq_can_alloc;

  assign in_ready = rob_can_enq & iq_can_alloc & sq_ok & ~flush_valid &
                    (rob_state == track_pkg::ROB_IDLE);

  assign fire = in_valid & in_ready;

  // rob side
  assign rob_enq              = fire;
  assign rob_entry.pc         = in_uop.pc;
  assign rob_entry.lrd        = in_uop.lrd;
  assign rob_entry.prd        = in_uop.prd;
  assign rob_entry.old_prd    = in_uop.old_prd;
  assign rob_entry.need_to_wb = in_uop.need_to_wb;

  // busy table lookups, sources straight from rename
  assign rd_preg1 = in_uop.prs1;
  assign rd_preg2 = in_uop.prs2;

  // destination becomes busy once the uop is in
  assign alloc_en   = fire & in_uop.need_to_wb;
  assign alloc_preg = in_uop.prd;

  // issue queue side
  assign iq_enq_valid       = fire;
  assign iq_entry.uop       = in_uop;
  assign iq_entry.robid     = rob_id;  // current rob tail
  assign iq_entry.sqid      = sq_id;   // current sq tail
  assign iq_entry.src1_busy = in_uop.src1_is_reg & src1_busy;  // imm operand never waits
  assign iq_entry.src2_busy = in_uop.src2_is_reg & src2_busy;

  // store queue side
  assign sq_enq   = fire & in_uop.is_store;
  assign sq_robid = rob_id;
  assign sq_pc    = in_uop.pc;

endmodule

// ==== design/dispatch_cfg.svh ====
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// physical and logical register index widths
`define PREG_W 6
`define LREG_W 5

// number of physical registers tracked by the busy table
`define PREG_NUM (1 << `PREG_W)

// reorder buffer, log2 of depth
`define ROB_SIZE_LOG 4
`define ROB_DEPTH (1 << `ROB_SIZE_LOG)

// store queue, log2 of depth
`define STOREQUEUE_LOG 3
`define SQ_DEPTH (1 << `STOREQUEUE_LOG)

`endif

// ==== design/dispatch_top.sv ====
module dispatch_top (
  input  logic                   clock,
  input  logic                   arst_n,
  // rename
  input  logic                   in_valid,
  output logic                   in_ready,
  input  uop_pkg::renamed_uop_t  in_uop,
  // issue queue
  input  logic                   iq_can_alloc,
  output logic                   iq_enq_valid,
  output uop_pkg::iq_entry_t     iq_entry,
  // writeback clear
  input  logic                   wb_valid,
  input  uop_pkg::preg_t         wb_preg,
  // store queue
  input  logic                   store_commit,
  output logic                   sq_enq_valid,
  output track_pkg::rob_id_t     sq_robid,
  output uop_pkg::pc_t           sq_pc,
  // rob retire
  input  logic                   commit,
  output logic                   rob_head_valid,
  output track_pkg::rob_entry_t  rob_head,
  input  logic                   flush_valid
);

  logic                  rob_can_enq;
  track_pkg::rob_id_t    rob_id;
  track_pkg::rob_state_e rob_state;
  logic                  rob_enq;
  track_pkg::rob_entry_t rob_entry;
  logic                  sq_can_alloc;
  track_pkg::sq_id_t     sq_id;
  uop_pkg::preg_t        rd_preg1;
  uop_pkg::preg_t        rd_preg2;
  logic                  src1_busy;
  logic                  src2_busy;
  logic                  alloc_en;
  uop_pkg::preg_t        alloc_preg;

  dispatch dispatch_i (
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_uop       (in_uop),
    .iq_can_alloc (iq_can_alloc),
    .iq_enq_valid (iq_enq_valid),
    .iq_entry     (iq_entry),
    .rob_can_enq  (rob_can_enq),
    .rob_id       (rob_id),
    .rob_state    (rob_state),
    .rob_enq      (rob_enq),
    .rob_entry    (rob_entry),
    .sq_can_alloc (sq_can_alloc),
    .sq_id        (sq_id),
    .sq_enq       (sq_enq_valid),
    .sq_robid     (sq_robid),
    .sq_pc        (sq_pc),
    .rd_preg1     (rd_preg1),
    .rd_preg2     (rd_preg2),
    .src1_busy    (src1_busy),
    .src2_busy    (src2_busy),
    .alloc_en     (alloc_en),
    .alloc_preg   (alloc_preg),
    .flush_valid  (flush_valid)
  );

  busy_table busy_table_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .flush_valid (flush_valid),
    .rd_preg1    (rd_preg1),
    .rd_preg2    (rd_preg2),
    .src1_busy   (src1_busy),
    .src2_busy   (src2_busy),
    .alloc_en    (alloc_en),
    .alloc_preg  (alloc_preg),
    .wb_valid    (wb_valid),
    .wb_preg     (wb_preg)
  );

  rob_tracker rob_tracker_i (
    .clock          (clock),
    .arst_n         (arst_n),
    .flush_valid    (flush_valid),
    .rob_enq        (rob_enq),
    .rob_entry      (rob_entry),
    .rob_can_enq    (rob_can_enq),
    .rob_id         (rob_id),
    .rob_state      (rob_state),
    .commit         (commit),
    .rob_head_valid (rob_head_valid),
    .rob_head       (rob_head)
  );

  sq_tracker sq_tracker_i (
    .clock        (clock),
    .arst_n       (arst_n),
    .flush_valid  (flush_valid),
    .sq_enq       (sq_enq_valid),
    .store_commit (store_commit),
    .sq_can_alloc (sq_can_alloc),
    .sq_id        (sq_id)
  );

endmodule

// ==== design/rob_tracker.sv ====
`include "dispatch_cfg.svh"

module rob_tracker (
  input  logic                   clock,
  input  logic                   arst_n,
  input  logic                   flush_valid,
  // allocation from dispatch
  input  logic                   rob_enq,
  input  track_pkg::rob_entry_t  rob_entry,
  output logic                   rob_can_enq,
  output track_pkg::rob_id_t     rob_id,
  output track_pkg::rob_state_e  rob_state,
  // retire side
  input  logic                   commit,
  output logic                   rob_head_valid,
  output track_pkg::rob_entry_t  rob_head
);

  track_pkg::rob_entry_t entries [`ROB_DEPTH];

  track_pkg::rob_id_t    head_q;
  track_pkg::rob_id_t    tail_q;
  track_pkg::rob_state_e state_q;
  track_pkg::rob_state_e state_d;

  logic rob_full;
  logic rob_empty;
  logic do_enq;
  logic do_commit;

  // same index, wrap bits decide full or empty
  assign rob_empty = (head_q == tail_q);
  assign rob_full  = (head_q[`ROB_SIZE_LOG-1:0] == tail_q[`ROB_SIZE_LOG-1:0]) &
                     (head_q[`ROB_SIZE_LOG] != tail_q[`ROB_SIZE_LOG]);

  assign do_enq    = rob_enq & ~rob_full;
  assign do_commit = commit & ~rob_empty;  // commit on empty rob is dropped

  always_comb begin
    state_d = state_q;
    case (state_q)
      track_pkg::ROB_IDLE: begin
        if (flush_valid)
          state_d = track_pkg::ROB_RECOVER;
      end
      track_pkg::ROB_RECOVER: begin
        if (!flush_valid)
          state_d = track_pkg::ROB_IDLE;  // one cycle of recovery
      end
      default: state_d = track_pkg::ROB_IDLE;
    endcase
  end

  // leaves reset through one recovery cycle
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      state_q <= track_pkg::ROB_RECOVER;
    end else begin
      state_q <= state_d;
      if (flush_valid) begin
        head_q <= '0;
        tail_q <= '0;
      end else begin
        if (do_enq)
          tail_q <= tail_q + 1'b1;
        if (do_commit)
          head_q <= head_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_enq)
      entries[tail_q[`ROB_SIZE_LOG-1:0]] <= rob_entry;
  end

  assign rob_can_enq    = ~rob_full;
  assign rob_id         = tail_q;
  assign rob_state      = state_q;
  assign rob_head_valid = ~rob_empty;
  assign rob_head       = entries[head_q[`ROB_SIZE_LOG-1:0]];

endmodule

// ==== design/sq_tracker.sv ====
`include "dispatch_cfg.svh"

module sq_tracker (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               flush_valid,
  input  logic               sq_enq,
  input  logic               store_commit,
  output logic               sq_can_alloc,
  output track_pkg::sq_id_t  sq_id
);

  track_pkg::sq_id_t head_q;
  track_pkg::sq_id_t tail_q;

  logic [`STOREQUEUE_LOG:0] sq_count;
  logic                     sq_full;
  logic                     sq_empty;

  // wrap bit makes the difference a true occupancy
  assign sq_count = tail_q - head_q;
  assign sq_full  = (sq_count == `SQ_DEPTH);
  assign sq_empty = (sq_count == '0);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head_q <= '0;
      tail_q <= '0;
    end else if (flush_valid) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (sq_enq && !sq_full)
        tail_q <= tail_q + 1'b1;
      if (store_commit && !sq_empty)
        head_q <= head_q + 1'b1;  // oldest store leaves
    end
  end

  assign sq_can_alloc = ~sq_full;
  assign sq_id        = tail_q;

endmodule

// ==== design/track_pkg.sv ====
`include "dispatch_cfg.svh"

package track_pkg;

  // ids carry one extra msb as the wrap bit
  typedef logic [`ROB_SIZE_LOG:0] rob_id_t;
  typedef logic [`STOREQUEUE_LOG:0] sq_id_t;

  // what the rob keeps per micro-op until commit
  typedef struct packed {
    logic [31:0]         pc;
    logic [`LREG_W-1:0]  lrd;
    logic [`PREG_W-1:0]  prd;
    logic [`PREG_W-1:0]  old_prd;  // freed at commit
    logic                need_to_wb;
  } rob_entry_t;

  // two bits wide, as on the rob state port
  typedef enum logic [1:0] {
    ROB_IDLE    = 2'b00,
    ROB_RECOVER = 2'b01
  } rob_state_e;

endpackage

// ==== design/uop_pkg.sv ====
`include "dispatch_cfg.svh"

package uop_pkg;

  typedef logic [`PREG_W-1:0] preg_t;
  typedef logic [`LREG_W-1:0] lreg_t;
  typedef logic [31:0]        pc_t;
  typedef logic [3:0]         alu_type_t;

  // micro-op as it leaves rename
  typedef struct packed {
    pc_t         pc;
    logic [31:0] instr;
    lreg_t       lrs1;
    lreg_t       lrs2;
    lreg_t       lrd;
    preg_t       prd;
    preg_t       old_prd;
    logic        need_to_wb;
    preg_t       prs1;
    preg_t       prs2;
    logic        src1_is_reg;  // 0 means imm or pc operand
    logic        src2_is_reg;
    logic [63:0] imm;
    alu_type_t   alu_type;
    logic        is_load;
    logic        is_store;
    logic [3:0]  ls_size;      // byte enable style size
    logic        predict_taken;
    logic [31:0] predict_target;
  } renamed_uop_t;

  // issue queue entry, the uop plus what dispatch adds
  typedef struct packed {
    renamed_uop_t     uop;
    track_pkg::rob_id_t robid;
    track_pkg::sq_id_t  sqid;
    logic             src1_busy;  // sleep bits for wakeup
    logic             src2_busy;
  } iq_entry_t;

endpackage

// ==== test/dispatch_chk.sv ====
module dispatch_chk (
  input logic                  clock,
  input logic                  arst_n,
  input logic                  in_ready,
  input logic                  iq_enq_valid,
  input logic                  sq_enq_valid,
  input logic                  flush_valid,
  input uop_pkg::renamed_uop_t in_uop
);

  int assert_errs = 0;  // read by the testbench at the end

  // issue queue only takes what dispatch accepted
  enq_needs_ready: assert property (@(posedge clock) disable iff (!arst_n)
    iq_enq_valid |-> in_ready)
    else begin
      $error("issue queue enqueue while in_ready is low");
      assert_errs++;
    end

  no_enq_on_flush: assert property (@(posedge clock) disable iff (!arst_n)
    flush_valid |-> !(iq_enq_valid || sq_enq_valid))
    else begin
      $error("enqueue in a flush cycle");
      assert_errs++;
    end

  // store queue slots are for stores only
  sq_only_stores: assert property (@(posedge clock) disable iff (!arst_n)
    sq_enq_valid |-> in_uop.is_store)
    else begin
      $error("store queue enqueue for a non-store uop");
      assert_errs++;
    end

endmodule

bind dispatch_top dispatch_chk chk_i (
  .clock        (clock),
  .arst_n       (arst_n),
  .in_ready     (in_ready),
  .iq_enq_valid (iq_enq_valid),
  .sq_enq_valid (sq_enq_valid),
  .flush_valid  (flush_valid),
  .in_uop       (in_uop)
);

// ==== test/dispatch_tb.sv ====
`include "dispatch_cfg.svh"

module dispatch_tb;

  logic                  clock;
  logic                  arst_n;
  logic                  in_valid;
  logic                  in_ready;
  uop_pkg::renamed_uop_t in_uop;
  logic                  iq_can_alloc;
  logic                  iq_enq_valid;
  uop_pkg::iq_entry_t    iq_entry;
  logic                  wb_valid;
  uop_pkg::preg_t        wb_preg;
  logic                  store_commit;
  logic                  sq_enq_valid;
  track_pkg::rob_id_t    sq_robid;
  uop_pkg::pc_t          sq_pc;
  logic                  commit;
  logic                  rob_head_valid;
  track_pkg::rob_entry_t rob_head;
  logic                  flush_valid;

  // predicted dispatch outputs for one cycle
  typedef struct packed {
    logic                  in_ready;
    logic                  iq_enq_valid;
    uop_pkg::iq_entry_t    iq_entry;
    logic                  sq_enq_valid;
    track_pkg::rob_id_t    sq_robid;
    uop_pkg::pc_t          sq_pc;
    logic                  rob_head_valid;
    track_pkg::rob_entry_t rob_head;
  } pred_t;

  // reference state
  track_pkg::rob_entry_t rob_q [$];
  track_pkg::rob_id_t    rob_tail;
  track_pkg::sq_id_t     sq_tail;
  int                    sq_cnt;
  logic [`PREG_NUM-1:0]  busy;
  logic                  recover;

  logic [31:0] lfsr = 32'd9981;
  int          val_errs = 0;
  int          other_errs = 0;
  logic        prev_fire = 1'b0;
  pred_t       pred;

  // stimulus knobs as thresholds out of 4 or 16
  int   valid_th;
  int   commit_th;
  int   scommit_th;
  int   store_th;
  logic flush_on;
  logic hold_on;

  dispatch_top dut_i (
    .clock          (clock),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_uop         (in_uop),
    .iq_can_alloc   (iq_can_alloc),
    .iq_enq_valid   (iq_enq_valid),
    .iq_entry       (iq_entry),
    .wb_valid       (wb_valid),
    .wb_preg        (wb_preg),
    .store_commit   (store_commit),
    .sq_enq_valid   (sq_enq_valid),
    .sq_robid       (sq_robid),
    .sq_pc          (sq_pc),
    .commit         (commit),
    .rob_head_valid (rob_head_valid),
    .rob_head       (rob_head),
    .flush_valid    (flush_valid)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // galois lfsr stepped once per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic uop_pkg::renamed_uop_t random_uop();
    uop_pkg::renamed_uop_t u;
    u.pc             = 32'(take_bits(32));
    u.instr          = 32'(take_bits(32));
    u.lrs1           = uop_pkg::lreg_t'(take_bits(`LREG_W));
    u.lrs2           = uop_pkg::lreg_t'(take_bits(`LREG_W));
    u.lrd            = uop_pkg::lreg_t'(take_bits(`LREG_W));
    u.prd            = uop_pkg::preg_t'(take_bits(`PREG_W));
    u.old_prd        = uop_pkg::preg_t'(take_bits(`PREG_W));
    u.prs1           = uop_pkg::preg_t'(take_bits(`PREG_W));
    u.prs2           = uop_pkg::preg_t'(take_bits(`PREG_W));
    u.src1_is_reg    = take_bits(2) != 0;
    u.src2_is_reg    = take_bits(2) != 0;
    u.imm            = take_bits(64);
    u.alu_type       = 4'(take_bits(4));
    u.is_store       = take_bits(4) < store_th;
    u.is_load        = ~u.is_store & take_bits(1) != 0;
    u.need_to_wb     = ~u.is_store & take_bits(3) != 0;  // stores write no register
    u.ls_size        = 4'(take_bits(4));
    u.predict_taken  = take_bits(1) != 0;
    u.predict_target = 32'(take_bits(32));
    return u;
  endfunction

  function automatic pred_t predict(input logic v, input uop_pkg::renamed_uop_t u,
                                    input logic iq_ok, input logic fl,
                                    input logic wbv, input uop_pkg::preg_t wbp);
    pred_t p;
    logic  room;
    room = (rob_q.size() < `ROB_DEPTH) && (!u.is_store || sq_cnt < `SQ_DEPTH);
    p.in_ready           = room && iq_ok && !fl && !recover;
    p.iq_enq_valid       = v && p.in_ready;
    p.iq_entry.uop       = u;
    p.iq_entry.robid     = rob_tail;
    p.iq_entry.sqid      = sq_tail;
    p.iq_entry.src1_busy = u.src1_is_reg && busy[u.prs1] && !(wbv && wbp == u.prs1);
    p.iq_entry.src2_busy = u.src2_is_reg && busy[u.prs2] && !(wbv && wbp == u.prs2);
    p.sq_enq_valid       = p.iq_enq_valid && u.is_store;
    p.sq_robid           = rob_tail;
    p.sq_pc              = u.pc;
    p.rob_head_valid     = rob_q.size() != 0;
    p.rob_head           = '0;
    if (p.rob_head_valid)
      p.rob_head = rob_q[0];
    return p;
  endfunction

  // what the edge does to the reference state
  function automatic void advance_model(input pred_t p, input uop_pkg::renamed_uop_t u,
                                        input logic cm, input logic scm, input logic fl,
                                        input logic wbv, input uop_pkg::preg_t wbp);
    logic sq_free;
    sq_free = scm && sq_cnt > 0;
    if (fl) begin
      rob_q.delete();
      rob_tail = '0;
      sq_tail  = '0;
      sq_cnt   = 0;
      busy     = '0;
      recover  = 1'b1;
    end else begin
      recover = 1'b0;
      if (cm && rob_q.size() > 0)
        void'(rob_q.pop_front());
      if (p.iq_enq_valid) begin
        rob_q.push_back({u.pc, u.lrd, u.prd, u.old_prd, u.need_to_wb});
        rob_tail = rob_tail + 1'b1;
      end
      if (p.sq_enq_valid) begin
        sq_tail = sq_tail + 1'b1;
        sq_cnt++;
      end
      if (sq_free)
        sq_cnt--;
      if (wbv)
        busy[wbp] = 1'b0;
      if (p.iq_enq_valid && u.need_to_wb)
        busy[u.prd] = 1'b1;  // set wins
      busy[0] = 1'b0;
    end
  endfunction

  task automatic bit_cmp(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      val_errs++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic entry_cmp(input string name, input uop_pkg::iq_entry_t got,
                           input uop_pkg::iq_entry_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic head_cmp(input string name, input track_pkg::rob_entry_t got,
                          input track_pkg::rob_entry_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic id_cmp(input string name, input track_pkg::rob_id_t got,
                        input track_pkg::rob_id_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic pc_cmp(input string name, input uop_pkg::pc_t got,
                        input uop_pkg::pc_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // sample just before each rising edge and step the model
  initial begin
    forever begin
      @(negedge clock);
      #1;
      if (arst_n) begin
        pred = predict(in_valid, in_uop, iq_can_alloc, flush_valid, wb_valid, wb_preg);
        bit_cmp("in_ready", in_ready, pred.in_ready);
        bit_cmp("iq_enq_valid", iq_enq_valid, pred.iq_enq_valid);
        entry_cmp("iq_entry", iq_entry, pred.iq_entry);
        bit_cmp("sq_enq_valid", sq_enq_valid, pred.sq_enq_valid);
        id_cmp("sq_robid", sq_robid, pred.sq_robid);
        pc_cmp("sq_pc", sq_pc, pred.sq_pc);
        bit_cmp("rob_head_valid", rob_head_valid, pred.rob_head_valid);
        if (pred.rob_head_valid)
          head_cmp("rob_head", rob_head, pred.rob_head);
        prev_fire = pred.iq_enq_valid;
        advance_model(pred, in_uop, commit, store_commit, flush_valid, wb_valid, wb_preg);
      end
    end
  end

  task automatic drive_cycle();
    @(posedge clock);
    #1;
    if (!(hold_on && in_valid && !prev_fire)) begin  // upstream keeps a stalled uop
      in_valid = take_bits(2) < valid_th;
      in_uop   = random_uop();
    end
    iq_can_alloc = take_bits(3) != 0;
    commit       = take_bits(4) < commit_th;
    store_commit = take_bits(4) < scommit_th;
    wb_valid     = take_bits(1) != 0;
    wb_preg      = uop_pkg::preg_t'(take_bits(`PREG_W));
    flush_valid  = flush_on && take_bits(6) == 0;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) drive_cycle();
  endtask

  task automatic flush_once();
    drive_cycle();
    flush_valid = 1'b1;
  endtask

  task automatic fill_rob(input int limit);
    int n;
    n = 0;
    while (rob_q.size() < `ROB_DEPTH && n < limit) begin
      drive_cycle();
      n++;
    end
    if (rob_q.size() < `ROB_DEPTH) begin
      other_errs++;
      $display("rob did not fill within %0d cycles", limit);
    end
  endtask

  task automatic saturate_sq(input int limit);
    int n;
    n = 0;
    while (sq_cnt < `SQ_DEPTH && n < limit) begin
      drive_cycle();
      n++;
    end
    if (sq_cnt < `SQ_DEPTH) begin
      other_errs++;
      $display("store queue did not fill within %0d cycles", limit);
    end
  endtask

  initial begin
    repeat (6000) @(posedge clock);
    $display("simulation ran past its cycle limit");
    $display("test failed");
    $finish;
  end

  initial begin
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_uop       = '0;
    iq_can_alloc = 1'b1;  // first cycle is blocked by rob recovery alone
    wb_valid     = 1'b0;
    wb_preg      = '0;
    store_commit = 1'b0;
    commit       = 1'b0;
    flush_valid  = 1'b0;
    rob_q.delete();
    rob_tail = '0;
    sq_tail  = '0;
    sq_cnt   = 0;
    busy     = '0;
    recover  = 1'b1;  // rob leaves reset through recovery
    valid_th   = 3;
    commit_th  = 8;
    scommit_th = 8;
    store_th   = 4;
    flush_on = 1'b1;
    hold_on  = 1'b1;
    repeat (4) @(posedge clock);
    #1 arst_n = 1'b1;

    run_cycles(300);

    // rob fills with no commits
    valid_th  = 4;
    commit_th = 0;
    store_th  = 2;
    flush_on  = 1'b0;
    fill_rob(200);
    run_cycles(6);
    commit_th = 8;
    run_cycles(20);

    // non-stores still go while the store queue is full
    store_th   = 12;
    scommit_th = 0;
    commit_th  = 12;
    saturate_sq(200);
    hold_on = 1'b0;
    run_cycles(20);
    hold_on    = 1'b1;
    scommit_th = 8;
    run_cycles(20);

    // directed flushes
    valid_th = 3;
    store_th = 4;
    flush_once();
    run_cycles(10);
    flush_once();
    run_cycles(5);

    flush_on = 1'b1;
    run_cycles(300);
    @(posedge clock);
    #1;

    $display("errors: %0d value, %0d other, %0d assertion",
             val_errs, other_errs, dut_i.chk_i.assert_errs);
    if (val_errs + other_errs + dut_i.chk_i.assert_errs == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule
